// File: Makefile
# Verilator build and regression run for the memory system

SIM      ?= verilator
VFLAGS   ?= --binary --timing -j 0
TOP      ?= tbMemSystem
FILELIST ?= memSystem.f
OBJDIR   ?= obj_dir
LOG      ?= sim.log
PASS_MSG ?= Regression passed

SRCS := $(wildcard src/*.sv src/*.svh) tests/tbMemSystem.sv
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS: see $(LOG)"; \
	else \
		echo "FAIL: see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: memSystem.f
+incdir+src
src/memSysPkg.sv
src/bankIf.sv
src/cacheWayIf.sv
src/cacheWay.sv
src/memBank.sv
src/memReturn.sv
src/cacheCtrl.sv
src/memSystem.sv
tests/tbMemSystem.sv

// File: src/bankIf.sv
// One instance per bank and reqValid may only rise while the controller holds a credit
`timescale 1ns/10ps
`default_nettype none

`include "memSys_consts.svh"

interface bankIf import memSysPkg::*; ();

    logic                         reqValid;
    reqOp_e                       reqOp;
    logic [`TAG_W+`INDEX_W-1:0]   reqAddr;     // Block address inside the bank
    logic [`DATA_W-1:0]           reqData;

    logic                         credit;      // One pulse per retired request
    logic                         respValid;
    logic [`DATA_W-1:0]           respData;

    modport ctrl (
        output reqValid, reqOp, reqAddr, reqData,
        input  credit
    );

    modport bank (
        input  reqValid, reqOp, reqAddr, reqData,
        output credit, respValid, respData
    );

    // Read results only
    modport drain (input respValid, respData);

endinterface

`default_nettype wire

// File: src/cacheCtrl.sv
// Request inputs must stay stable until done and writes report no cache hit
`timescale 1ns/10ps
`default_nettype none

`include "memSys_consts.svh"

module cacheCtrl import memSysPkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic [`ADDR_W-1:0]  addr,
    input  logic [`DATA_W-1:0]  dataIn,
    input  logic                rd,
    input  logic                wr,
    input  logic                fillValid,
    input  fillWord_t           fill,
    output logic [`DATA_W-1:0]  dataOut,
    output logic                done,
    output logic                stall,
    output logic                cacheHit,
    output logic                err,
    cacheWayIf.ctrl             ways  [`NUM_WAYS],
    bankIf.ctrl                 banks [`NUM_BANKS]
);

    localparam int NW     = `NUM_WAYS;
    localparam int NB     = `NUM_BANKS;
    localparam int WAY_W  = (NW > 1) ? $clog2(NW) : 1;
    localparam int CRED_W = $clog2(`BANK_CREDITS + 1);
    localparam int CNT_W  = `WORD_W + 1;
    localparam int SETS   = 1 << `INDEX_W;

    ctrlState_e         state;
    ctrlState_e         nextState;
    reqOp_e             op;
    logic               errReg;
    logic               hitReg;
    logic               missSeen;    // Block was allocated for this request
    logic [`TAG_W-1:0]  tag;
    logic [`INDEX_W-1:0] index;
    logic [`WORD_W-1:0] wordSel;
    logic [NW-1:0]      wayHit;
    logic [NW-1:0]      wayValid;
    logic [`DATA_W-1:0] wayData [NW];
    logic               anyHit;
    logic [`DATA_W-1:0] hitData;
    logic [WAY_W-1:0]   victim;
    logic [WAY_W-1:0]   victimPick;
    logic [SETS-1:0]    victimBit;
    logic [CRED_W-1:0]  credits [NB];
    logic [NB-1:0]      bankCredit;
    logic [NB-1:0]      hasCredit;
    logic [NB-1:0]      issue;
    logic [NB-1:0]      issued;
    logic [CNT_W-1:0]   fillCnt;
    logic               allocating;
    logic               lastFill;
    logic               accept;
    logic               badReq;

    // Request decode
    assign tag        = addr[`ADDR_W-1 -: `TAG_W];
    assign index      = addr[`WORD_W+1 +: `INDEX_W];
    assign wordSel    = addr[1 +: `WORD_W];
    assign accept     = (state == IDLE) && (rd || wr);
    assign badReq     = addr[0] || (rd && wr);
    assign allocating = (state == ALLOC_ISSUE) || (state == ALLOC_FILL);
    assign lastFill   = allocating && fillValid && (fillCnt == CNT_W'(NB - 1));
    assign anyHit     = |wayHit;

    always_comb begin
        hitData = wayData[0];
        for (int w = 0; w < NW; w++) begin
            if (wayHit[w]) hitData = wayData[w];
        end
    end

    // First invalid way wins, otherwise the set's victim bit
    always_comb begin
        victimPick = WAY_W'(victimBit[index]);
        for (int w = NW - 1; w >= 0; w--) begin
            if (!wayValid[w]) victimPick = WAY_W'(w);
        end
    end

    for (genvar w = 0; w < NW; w++) begin : g_way
        assign wayHit[w]       = ways[w].hit;
        assign wayValid[w]     = ways[w].valid;
        assign wayData[w]      = ways[w].rdData;
        assign ways[w].index   = index;
        assign ways[w].tag     = tag;
        assign ways[w].wordSel = allocating ? fill.word : wordSel;
        assign ways[w].wrData  = allocating ? fill.data : dataIn;
        assign ways[w].wrEn    = (state == COMPARE && op == OP_WRITE && wayHit[w])
                               || (allocating && fillValid && victim == WAY_W'(w));
        assign ways[w].fillTag = lastFill && (victim == WAY_W'(w));
    end

    for (genvar b = 0; b < NB; b++) begin : g_bank
        assign bankCredit[b] = banks[b].credit;
        assign hasCredit[b]  = (credits[b] != '0);
        assign issue[b]      = hasCredit[b]
                             && ((state == WRITE_MEM && wordSel == `WORD_W'(b))
                                 || (state == ALLOC_ISSUE && !issued[b]));
        assign banks[b].reqValid = issue[b];
        assign banks[b].reqOp    = (state == WRITE_MEM) ? OP_WRITE : OP_READ;
        assign banks[b].reqAddr  = addr[`ADDR_W-1 : `WORD_W+1];
        assign banks[b].reqData  = dataIn;

        always_ff @(posedge clk) begin
            if (rst) credits[b] <= CRED_W'(`BANK_CREDITS);
            else credits[b] <= credits[b] - CRED_W'(issue[b]) + CRED_W'(bankCredit[b]);
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            IDLE:        if (rd || wr) nextState = badReq ? FINISH : COMPARE;
            COMPARE:     nextState = (op == OP_WRITE) ? WRITE_MEM
                                   : (anyHit ? FINISH : ALLOC_ISSUE);
            WRITE_MEM:   if (hasCredit[wordSel]) nextState = FINISH;    // Held under back-pressure
            ALLOC_ISSUE: if ((issued | issue) == '1) nextState = ALLOC_FILL;
            ALLOC_FILL:  if (lastFill) nextState = COMPARE;
            FINISH:      nextState = IDLE;
            default:     nextState = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            op        <= OP_READ;
            errReg    <= 1'b0;
            hitReg    <= 1'b0;
            missSeen  <= 1'b0;
            victim    <= '0;
            victimBit <= '0;
            issued    <= '0;
            fillCnt   <= '0;
        end else begin
            state <= nextState;
            if (accept) begin
                op       <= wr ? OP_WRITE : OP_READ;
                errReg   <= badReq;
                hitReg   <= 1'b0;
                missSeen <= 1'b0;
            end
            if (state == COMPARE && op == OP_READ) begin
                if (anyHit) begin
                    hitReg <= !missSeen;
                end else begin
                    missSeen         <= 1'b1;
                    victim           <= victimPick;
                    victimBit[index] <= ~victimBit[index];    // Flips on each allocation
                    issued           <= '0;
                    fillCnt          <= '0;
                end
            end
            if (state == ALLOC_ISSUE) issued <= issued | issue;
            if (allocating && fillValid) fillCnt <= fillCnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == COMPARE && anyHit) dataOut <= hitData;
    end

    assign done     = (state == FINISH);
    assign stall    = (state != IDLE);
    assign err      = done && errReg;
    assign cacheHit = done && hitReg;

endmodule

`default_nettype wire

// File: src/cacheWay.sv
// Single cache way with asynchronous lookup and writes visible one cycle after wrEn
`timescale 1ns/10ps
`default_nettype none

`include "memSys_consts.svh"

module cacheWay (
    input  logic    clk,
    input  logic    rst,
    cacheWayIf.way  port
);

    localparam int SETS  = 1 << `INDEX_W;
    localparam int WORDS = SETS << `WORD_W;

    logic [`TAG_W-1:0]  tagMem  [SETS];
    logic [`DATA_W-1:0] dataMem [WORDS];    // Indexed by {set, word}
    logic [SETS-1:0]    validMem;

    logic tagMatch;

    // Lookup
    assign tagMatch    = (tagMem[port.index] == port.tag);
    assign port.valid  = validMem[port.index];
    assign port.hit    = validMem[port.index] && tagMatch;
    assign port.rdData = dataMem[{port.index, port.wordSel}];

    // Valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            validMem <= '0;
        end else if (port.fillTag) begin
            validMem[port.index] <= 1'b1;
        end
    end

    // Tag and data arrays
    always_ff @(posedge clk) begin
        if (port.fillTag) begin
            tagMem[port.index] <= port.tag;
        end
        if (port.wrEn) begin
            dataMem[{port.index, port.wordSel}] <= port.wrData;    // Hit update or block fill
        end
    end

endmodule

`default_nettype wire

// File: src/cacheWayIf.sv
// One instance per way and hit, valid and rdData are combinational from index and tag
`timescale 1ns/10ps
`default_nettype none

`include "memSys_consts.svh"

interface cacheWayIf ();

    logic [`INDEX_W-1:0] index;
    logic [`TAG_W-1:0]   tag;
    logic [`WORD_W-1:0]  wordSel;
    logic                wrEn;
    logic [`DATA_W-1:0]  wrData;
    logic                fillTag;    // Store tag and mark set valid

    logic [`DATA_W-1:0]  rdData;
    logic                hit;
    logic                valid;

    modport ctrl (output index, tag, wordSel, wrEn, wrData, fillTag,
                  input  rdData, hit, valid);

    modport way  (input  index, tag, wordSel, wrEn, wrData, fillTag,
                  output rdData, hit, valid);

endinterface

`default_nettype wire

// File: src/memBank.sv
// Fixed latency bank that relies on the sender never exceeding BANK_CREDITS outstanding requests
`timescale 1ns/10ps
`default_nettype none

`include "memSys_consts.svh"

module memBank import memSysPkg::*; (
    input  logic  clk,
    input  logic  rst,
    bankIf.bank   port
);

    localparam int DEPTH   = `BANK_CREDITS;
    localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int AGE_W   = $clog2(`BANK_LATENCY + 1);
    localparam int BADDR_W = `TAG_W + `INDEX_W;

    logic [`DATA_W-1:0] words [`BANK_WORDS];

    // In-flight queue
    logic [DEPTH-1:0]   busy;
    logic [AGE_W-1:0]   age   [DEPTH];    // Cycles spent in the pipeline
    reqOp_e             qOp   [DEPTH];
    logic [BADDR_W-1:0] qAddr [DEPTH];
    logic [`DATA_W-1:0] qData [DEPTH];
    logic [PTR_W-1:0]   head;
    logic [PTR_W-1:0]   tail;
    logic               leave;

    // Oldest entry retires once it has spent the full latency
    assign leave = busy[head] && (age[head] == AGE_W'(`BANK_LATENCY));

    // Contents start at zero
    initial begin
        for (int i = 0; i < `BANK_WORDS; i++) begin
            words[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy           <= '0;
            head           <= '0;
            tail           <= '0;
            port.credit    <= 1'b0;
            port.respValid <= 1'b0;
            for (int i = 0; i < DEPTH; i++) begin
                age[i] <= '0;
            end
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (busy[i]) age[i] <= age[i] + 1'b1;
            end
            if (leave) begin
                busy[head] <= 1'b0;
                head       <= (head == PTR_W'(DEPTH - 1)) ? '0 : head + 1'b1;
            end
            if (port.reqValid) begin
                busy[tail] <= 1'b1;
                age[tail]  <= AGE_W'(1);
                tail       <= (tail == PTR_W'(DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            port.credit    <= leave;                              // Every retire frees a slot
            port.respValid <= leave && (qOp[head] == OP_READ);
        end
    end

    always_ff @(posedge clk) begin
        if (port.reqValid) begin
            qOp[tail]   <= port.reqOp;
            qAddr[tail] <= port.reqAddr;
            qData[tail] <= port.reqData;
        end
        if (leave) begin
            if (qOp[head] == OP_WRITE) words[qAddr[head]] <= qData[head];
            else port.respData <= words[qAddr[head]];
        end
    end

endmodule

`default_nettype wire

// File: src/memReturn.sv
// Holds one read result per bank and assumes a bank never returns while its slot is full
`timescale 1ns/10ps
`default_nettype none

`include "memSys_consts.svh"

module memReturn import memSysPkg::*; (
    input  logic         clk,
    input  logic         rst,
    bankIf.drain         banks [`NUM_BANKS],
    output logic         fillValid,
    output fillWord_t    fill
);

    localparam int NB = `NUM_BANKS;

    logic [NB-1:0]      respV;
    logic [`DATA_W-1:0] respD    [NB];
    logic [NB-1:0]      held;
    logic [`DATA_W-1:0] heldData [NB];
    logic [NB-1:0]      pending;    // Held or arriving this cycle
    logic [NB-1:0]      pick;
    logic [`WORD_W-1:0] ptr;
    logic [`WORD_W-1:0] sel;
    logic               found;

    for (genvar b = 0; b < NB; b++) begin : g_tap
        assign respV[b] = banks[b].respValid;
        assign respD[b] = banks[b].respData;
    end

    assign pending = held | respV;

    // Round robin search starting at ptr
    always_comb begin
        logic [`WORD_W-1:0] cand;
        found = 1'b0;
        sel   = ptr;
        for (int k = 0; k < NB; k++) begin
            cand = ptr + `WORD_W'(k);
            if (!found && pending[cand]) begin
                found = 1'b1;
                sel   = cand;
            end
        end
        pick = '0;
        if (found) pick[sel] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            held      <= '0;
            ptr       <= '0;
            fillValid <= 1'b0;
        end else begin
            held      <= pending & ~pick;
            fillValid <= found;
            if (found) ptr <= sel + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < NB; b++) begin
            if (respV[b]) heldData[b] <= respD[b];
        end
        if (found) begin
            fill.word <= sel;
            fill.data <= held[sel] ? heldData[sel] : respD[sel];    // Bypass a fresh result
        end
    end

endmodule

`default_nettype wire

// File: src/memSysPkg.sv
// Types shared by the cache controller, the bank interface and the return collector
`default_nettype none

`include "memSys_consts.svh"

package memSysPkg;

    // Controller FSM
    typedef enum logic [2:0] {
        IDLE,
        COMPARE,
        WRITE_MEM,
        ALLOC_ISSUE,
        ALLOC_FILL,
        FINISH
    } ctrlState_e;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } reqOp_e;

    // One word of a block being filled
    typedef struct packed {
        logic [`WORD_W-1:0] word;    // Word index equals bank number
        logic [`DATA_W-1:0] data;
    } fillWord_t;

endpackage

`default_nettype wire

// File: src/memSys_consts.svh
// NUM_BANKS must equal the words per block and the bank word address is TAG_W + INDEX_W bits
`ifndef MEMSYS_CONSTS_SVH
`define MEMSYS_CONSTS_SVH

// Address split
`define ADDR_W 16
`define DATA_W 16
`define TAG_W 5
`define INDEX_W 8
`define WORD_W 2

// Cache shape
`define NUM_WAYS 2

// Main memory
`define NUM_BANKS 4
`define BANK_WORDS 8192
`define BANK_LATENCY 4
`define BANK_CREDITS 2    // Request queue depth per bank

`endif

// File: src/memSystem.sv
// Two-way write-through cache over four interleaved banks and bit 0 of addr must be zero
`timescale 1ns/10ps
`default_nettype none

`include "memSys_consts.svh"

module memSystem import memSysPkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic [`ADDR_W-1:0]  addr,
    input  logic [`DATA_W-1:0]  dataIn,
    input  logic                rd,
    input  logic                wr,
    output logic [`DATA_W-1:0]  dataOut,
    output logic                done,
    output logic                stall,
    output logic                cacheHit,
    output logic                err
);

    cacheWayIf wayBus  [`NUM_WAYS] ();
    bankIf     bankBus [`NUM_BANKS] ();

    logic      fillValid;
    fillWord_t fill;          // Collector to controller

    cacheCtrl ctrl (
        .clk       (clk),
        .rst       (rst),
        .addr      (addr),
        .dataIn    (dataIn),
        .rd        (rd),
        .wr        (wr),
        .fillValid (fillValid),
        .fill      (fill),
        .dataOut   (dataOut),
        .done      (done),
        .stall     (stall),
        .cacheHit  (cacheHit),
        .err       (err),
        .ways      (wayBus),
        .banks     (bankBus)
    );

    // Drains read results from every bank
    memReturn ret (
        .clk       (clk),
        .rst       (rst),
        .banks     (bankBus),
        .fillValid (fillValid),
        .fill      (fill)
    );

    for (genvar w = 0; w < `NUM_WAYS; w++) begin : g_ways
        cacheWay way (.clk(clk), .rst(rst), .port(wayBus[w]));
    end

    for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_banks
        memBank bank (.clk(clk), .rst(rst), .port(bankBus[b]));    // Bank b holds word b of each block
    end

endmodule

`default_nettype wire

// File: tests/tbMemSystem.sv
// Directed tests against a reference model. Bank contents must start at zero and are never reset
`timescale 1ns/10ps
`default_nettype none

`include "memSys_consts.svh"

module tbMemSystem import memSysPkg::*; ();

    localparam int TIMEOUT = 200;    // Cycles allowed per request
    localparam int SETS    = 1 << `INDEX_W;

    logic                clk = 1'b0;
    logic                rst;
    logic [`ADDR_W-1:0]  addr;
    logic [`DATA_W-1:0]  dataIn;
    logic                rd;
    logic                wr;
    logic [`DATA_W-1:0]  dataOut;
    logic                done;
    logic                stall;
    logic                cacheHit;
    logic                err;

    // Reference model
    logic [`DATA_W-1:0]  refMem    [1 << (`ADDR_W - 1)];
    logic                refValid  [`NUM_WAYS][SETS];
    logic [`TAG_W-1:0]   refTag    [`NUM_WAYS][SETS];
    logic                refVictim [SETS];

    logic [`DATA_W-1:0]  lastData;
    logic                lastHit;
    logic                lastErr;
    logic                timedOut = 1'b0;    // DUT stopped answering
    int                  lastCycles;
    int                  checks = 0;
    int                  errors = 0;
    int                  testErrBase = 0;
    integer              seed = 42034;

    memSystem uut (
        .clk(clk), .rst(rst), .addr(addr), .dataIn(dataIn), .rd(rd), .wr(wr),
        .dataOut(dataOut), .done(done), .stall(stall), .cacheHit(cacheHit), .err(err)
    );

    always #2 clk = ~clk;    // 4 ns period

    function automatic logic [`ADDR_W-1:0] makeAddr(input int t, input int idx, input int w);
        return {t[`TAG_W-1:0], idx[`INDEX_W-1:0], w[`WORD_W-1:0], 1'b0};
    endfunction

    task automatic checkData(input string name, input logic [`DATA_W-1:0] got,
                             input logic [`DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic checkCycles(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // Applies the rules of the memory system to the model state
    task automatic modelAccess(input logic [`ADDR_W-1:0] a, input logic [`DATA_W-1:0] d,
                               input logic r, input logic w, output logic [`DATA_W-1:0] expData,
                               output logic expHit, output logic expErr);
        logic [`INDEX_W-1:0] idx;
        logic [`TAG_W-1:0]   t;
        int                  way;
        idx     = a[`WORD_W+1 +: `INDEX_W];
        t       = a[`ADDR_W-1 -: `TAG_W];
        expErr  = a[0] || (r && w);
        expHit  = 1'b0;
        expData = refMem[a[`ADDR_W-1:1]];
        way     = -1;
        if (expErr) begin
            expHit = 1'b0;    // Nothing changes
        end else if (w) begin
            refMem[a[`ADDR_W-1:1]] = d;    // Write-through, no allocate
        end else begin
            for (int i = 0; i < `NUM_WAYS; i++) begin
                if (refValid[i][idx] && refTag[i][idx] == t) way = i;
            end
            if (way >= 0) begin
                expHit = 1'b1;
            end else begin
                way = refVictim[idx];
                for (int i = `NUM_WAYS - 1; i >= 0; i--) begin
                    if (!refValid[i][idx]) way = i;
                end
                refVictim[idx]     = ~refVictim[idx];
                refValid[way][idx] = 1'b1;
                refTag[way][idx]   = t;
            end
        end
    endtask

    // One request on the top-level ports, waits for done
    task automatic busAccess(input logic [`ADDR_W-1:0] a, input logic [`DATA_W-1:0] d,
                             input logic r, input logic w);
        logic seen;
        seen       = 1'b0;
        lastCycles = 0;
        if (!timedOut) begin
            addr   = a;
            dataIn = d;
            rd     = r;
            wr     = w;
            while (!seen && lastCycles < TIMEOUT) begin
                @(posedge clk);
                #1;
                lastCycles++;
                seen = done;
                checkFlag("stall", stall, 1'b1);    // Busy from the cycle after acceptance
            end
            if (!seen) begin
                timedOut = 1'b1;
                errors++;
                rd = 1'b0;
                wr = 1'b0;
                $display("Timeout: no done within %0d cycles for address %h", TIMEOUT, a);
            end else begin
                lastData = dataOut;
                lastHit  = cacheHit;
                lastErr  = err;
                rd = 1'b0;
                wr = 1'b0;
                @(posedge clk);    // Back to IDLE
                #1;
                checkFlag("done", done, 1'b0);
                checkFlag("stall", stall, 1'b0);
            end
        end
    endtask

    task automatic runAccess(input logic [`ADDR_W-1:0] a, input logic [`DATA_W-1:0] d,
                             input logic r, input logic w);
        logic [`DATA_W-1:0] expData;
        logic               expHit;
        logic               expErr;
        modelAccess(a, d, r, w, expData, expHit, expErr);
        busAccess(a, d, r, w);
        if (!timedOut) begin
            checkFlag("err", lastErr, expErr);
            checkFlag("cacheHit", lastHit, expHit);
            if (r && !expErr) checkData("dataOut", lastData, expData);
            if (expErr) checkCycles("error latency", lastCycles, 1);
            else if (r && expHit) checkCycles("hit latency", lastCycles, 2);
        end
    endtask

    task automatic finishTest(input string name);
        $display("%s: %s, %0d errors", name, (errors == testErrBase) ? "ok" : "mismatches",
                 errors - testErrBase);
        testErrBase = errors;
    endtask

    task automatic testReset();
        checkFlag("done", done, 1'b0);
        checkFlag("stall", stall, 1'b0);
        checkFlag("err", err, 1'b0);
        checkFlag("cacheHit", cacheHit, 1'b0);
        runAccess(makeAddr(1, 8'h20, 2), '0, 1'b1, 1'b0);
        checkData("first read", lastData, 16'h0000);
        finishTest("Reset state");
    endtask

    task automatic testMissThenHits();
        runAccess(makeAddr(3, 8'h12, 1), 16'hA5C3, 1'b0, 1'b1);
        runAccess(makeAddr(3, 8'h12, 1), '0, 1'b1, 1'b0);
        checkFlag("cacheHit on miss", lastHit, 1'b0);
        for (int w = 0; w < 4; w++) begin
            if (w != 1) runAccess(makeAddr(3, 8'h12, w), '0, 1'b1, 1'b0);
        end
        finishTest("Read miss then hits");
    endtask

    task automatic testWriteThrough();
        runAccess(makeAddr(3, 8'h12, 2), 16'h5A17, 1'b0, 1'b1);    // Resident block
        runAccess(makeAddr(3, 8'h12, 2), '0, 1'b1, 1'b0);
        runAccess(makeAddr(6, 8'h33, 3), 16'hBEEF, 1'b0, 1'b1);    // Not resident
        runAccess(makeAddr(6, 8'h33, 3), '0, 1'b1, 1'b0);
        checkFlag("cacheHit after no-allocate write", lastHit, 1'b0);
        // Push tag 3 out of its set, then memory must hold the write
        runAccess(makeAddr(4, 8'h12, 0), '0, 1'b1, 1'b0);
        runAccess(makeAddr(5, 8'h12, 0), '0, 1'b1, 1'b0);
        runAccess(makeAddr(3, 8'h12, 2), '0, 1'b1, 1'b0);
        checkFlag("cacheHit after eviction", lastHit, 1'b0);
        finishTest("Write-through and no allocate");
    endtask

    task automatic testVictim();
        runAccess(makeAddr(1, 8'h40, 0), '0, 1'b1, 1'b0);
        runAccess(makeAddr(2, 8'h40, 0), '0, 1'b1, 1'b0);
        runAccess(makeAddr(7, 8'h40, 0), '0, 1'b1, 1'b0);    // Evicts tag 1
        runAccess(makeAddr(2, 8'h40, 0), '0, 1'b1, 1'b0);
        checkFlag("cacheHit kept tag", lastHit, 1'b1);
        runAccess(makeAddr(1, 8'h40, 0), '0, 1'b1, 1'b0);
        checkFlag("cacheHit evicted tag", lastHit, 1'b0);
        finishTest("Victim choice");
    endtask

    task automatic testErrors();
        runAccess(makeAddr(3, 8'h12, 2) | 16'h0001, '0, 1'b1, 1'b0);
        runAccess(makeAddr(3, 8'h12, 2) | 16'h0001, 16'hFFFF, 1'b0, 1'b1);
        runAccess(makeAddr(6, 8'h33, 3), 16'h0000, 1'b1, 1'b1);    // Read and write together
        runAccess(makeAddr(6, 8'h33, 3), '0, 1'b1, 1'b0);
        runAccess(makeAddr(3, 8'h12, 2), '0, 1'b1, 1'b0);
        finishTest("Errors");
    endtask

    task automatic testRandomMix();
        logic [31:0] r;
        reqOp_e      op;
        int          idx;
        for (int n = 0; n < 200; n++) begin
            r   = $random(seed);
            op  = r[0] ? OP_WRITE : OP_READ;
            idx = 8'h05 + (r[9:8] % 3);
            runAccess(makeAddr(r[5:4], idx, r[3:2]), r[31:16], op == OP_READ, op == OP_WRITE);
        end
        finishTest("Random mix");
    endtask

    initial begin
        rst    = 1'b1;
        addr   = '0;
        dataIn = '0;
        rd     = 1'b0;
        wr     = 1'b0;
        for (int i = 0; i < (1 << (`ADDR_W - 1)); i++) refMem[i] = '0;
        for (int s = 0; s < SETS; s++) begin
            refVictim[s] = 1'b0;
            for (int w = 0; w < `NUM_WAYS; w++) refValid[w][s] = 1'b0;
        end
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        testReset();
        testMissThenHits();
        testWriteThrough();
        testVictim();
        testErrors();
        testRandomMix();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
